// File: project.f
src/fe_pkg.sv
src/fe_table.sv
src/fe_btb.sv
src/fe_dir_pred.sv
src/fe_ras.sv
src/fe_pc_gen.sv
src/fe_top.sv
tests/fe_properties.sv
tests/fe_tb.sv

// File: Makefile
# Verilator build and run of the fetch front end testbench

LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module fe_tb -f project.f -o vsim
	./obj_dir/vsim | tee $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) && echo "PASS" || \
		(echo "FAIL"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/fe_tb.sv
// testbench for fe_top, runs a stimulus table against a reference model of the front end
`timescale 1ns/1ps

module fe_tb;

  import fe_pkg::*;

  localparam addr_t RESET_PC  = 48'h0000_0000_1000;
  localparam int    RAS_DEPTH = 8;
  localparam int    MAX_ROWS  = 128;

  typedef struct packed {
    logic    rv;
    retire_t r;
    logic    bp;     // random back-pressure
    int      idle;   // quiet cycles after the row
  } row_t;

  logic    clk;
  logic    rst;
  fetch_t  fetch;
  logic    fetch_valid;
  logic    fetch_ready;
  logic    retire_valid;
  retire_t retire;

  row_t        rows [MAX_ROWS];
  int          n_rows;
  int          cycles;
  int          limit;
  int          n_hs;
  logic [31:0] rng;

  // reference model state
  logic             m_v    [64];
  logic [ADDR_W-1:10] m_tag [64];
  addr_t            m_tgt  [64];
  br_kind_t         m_kind [64];
  logic             m_a [1024];
  logic             m_b [1024];
  logic             m_c [1024];
  logic [3:0]       m_cnt;
  addr_t            m_ras [RAS_DEPTH];
  int               m_ptr;
  addr_t            m_pc;
  ghist_t           m_gh;

  fe_top #(
    .RESET_PC  (RESET_PC),
    .RAS_DEPTH (RAS_DEPTH)
  ) uut (
    .clk          (clk),
    .rst          (rst),
    .fetch        (fetch),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > limit) begin
      $display("timeout: test did not finish within %0d cycles", limit);
      $display("Simulation failed");
      $fatal(1, "timeout");
    end
  end

  function automatic logic [31:0] xorshift(logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [9:0] idx_a(addr_t a, ghist_t g);
    return {a[11:4], g[1:0]};
  endfunction

  function automatic logic [9:0] idx_b(addr_t a, ghist_t g);
    return {a[7:4], g[5:0]};
  endfunction

  function automatic logic [9:0] idx_c(ghist_t g);
    return g[9:0];
  endfunction

  function automatic retire_t mk_retire(addr_t src, addr_t tgt, ghist_t gh, br_kind_t kind,
                                        logic taken, logic misp);
    retire_t r;
    r.src        = src;
    r.target     = tgt;
    r.ghist      = gh;
    r.kind       = kind;
    r.taken      = taken;
    r.mispredict = misp;
    return r;
  endfunction

  task automatic fail_now();
    $display("Simulation failed");
    $fatal(1, "check failed");
  endtask

  task automatic check_fetch(fetch_t got, fetch_t exp);
    if (got !== exp) begin
      $display("** Error at %0t: fetch got %h expected %h (handshake %0d)",
               $time, got, exp, n_hs);
      fail_now();
    end
  endtask

  task automatic check_addr(addr_t got, addr_t exp, string what);
    if (got !== exp) begin
      $display("** Error at %0t: %s got %h expected %h", $time, what, got, exp);
      fail_now();
    end
  endtask

  task automatic check_valid(logic got, logic exp);
    if (got !== exp) begin
      $display("** Error at %0t: fetch_valid got %b expected %b", $time, got, exp);
      fail_now();
    end
  endtask

  task automatic add_row(logic rv, retire_t r, logic bp, int idle);
    rows[n_rows].rv   = rv;
    rows[n_rows].r    = r;
    rows[n_rows].bp   = bp;
    rows[n_rows].idle = idle;
    n_rows++;
  endtask

  // one cycle of the model, inputs as the DUT sees them at the coming edge
  task automatic model_step(logic rv, retire_t r, logic rdy);
    logic [5:0] bi;
    logic       hit;
    logic       pt;
    logic       tk;
    logic       redir;
    logic       hs;
    fetch_t     exp;
    addr_t      nxt;
    logic [9:0] ia;
    logic [9:0] ib;
    logic [9:0] ic;
    bi    = m_pc[9:4];
    hit   = m_v[bi] && (m_tag[bi] == m_pc[ADDR_W-1:10]);
    pt    = m_a[idx_a(m_pc, m_gh)] ^ m_b[idx_b(m_pc, m_gh)] ^ m_c[idx_c(m_gh)];
    tk    = hit && ((m_kind[bi] != BR_COND) || pt);
    redir = rv && r.mispredict;
    check_valid(fetch_valid, !redir);
    hs = !redir && rdy;
    if (hs) begin
      exp.pc    = m_pc;
      exp.ghist = m_gh;
      exp.taken = tk;
      exp.hit   = hit;
      exp.kind  = m_kind[bi];
      check_fetch(fetch, exp);
      n_hs++;
    end
    if (redir) begin
      if (r.taken) m_pc = {r.target[ADDR_W-1:4], 4'h0};
      else m_pc = {r.src[ADDR_W-1:4], 4'h0} + 48'd16;
      if (r.kind == BR_COND) m_gh = {r.ghist[14:0], r.taken};
      else m_gh = r.ghist;
    end else if (hs) begin
      if (!tk) nxt = m_pc + 48'd16;
      else if (m_kind[bi] == BR_RET) nxt = m_ras[m_ptr];
      else nxt = {m_tgt[bi][ADDR_W-1:4], 4'h0};
      if (hit && m_kind[bi] == BR_CALL) begin
        m_ptr = (m_ptr + 1) % RAS_DEPTH;
        m_ras[m_ptr] = m_pc + 48'd16;
      end else if (hit && m_kind[bi] == BR_RET) begin
        m_ptr = (m_ptr + RAS_DEPTH - 1) % RAS_DEPTH;
      end
      if (hit) m_gh = {m_gh[14:0], tk};
      m_pc = nxt;
    end
    if (rv && r.taken) begin   // install
      m_v[r.src[9:4]]    = 1'b1;
      m_tag[r.src[9:4]]  = r.src[ADDR_W-1:10];
      m_tgt[r.src[9:4]]  = r.target;
      m_kind[r.src[9:4]] = r.kind;
    end
    if (redir && r.kind == BR_COND) begin
      ia = idx_a(r.src, r.ghist);
      ib = idx_b(r.src, r.ghist);
      ic = idx_c(r.ghist);
      m_a[ia] = ~m_a[ia];
      if (m_cnt[1:0] == 2'b11) m_b[ib] = ~m_b[ib];
      if (m_cnt == 4'hf) m_c[ic] = ~m_c[ic];
      m_cnt = m_cnt + 4'd1;
    end
  endtask

  task automatic run_cycle(logic rv, retire_t r, logic bp);
    logic rdy;
    if (bp) begin
      rng = xorshift(rng);
      rdy = rng[0];
    end else begin
      rdy = 1'b1;
    end
    @(posedge clk);
    retire_valid <= rv;
    retire       <= r;
    fetch_ready  <= rdy;
    @(negedge clk);
    model_step(rv, r, rdy);
  endtask

  task automatic build_table();
    ghist_t gh;
    addr_t  blk;
    // sequential run from reset
    add_row(1'b0, '0, 1'b0, 6);
    // unconditional install, then steer fetch onto it
    add_row(1'b1, mk_retire(48'h2080, 48'h3000, '0, BR_UNCOND, 1'b1, 1'b0), 1'b0, 2);
    add_row(1'b1, mk_retire(48'h2070, '0, 16'h00a5, BR_UNCOND, 1'b0, 1'b1), 1'b0, 4);
    // conditional mispredicts, same history first then mixed
    for (int k = 0; k < 20; k++) begin
      gh = (k < 10) ? 16'h1234 : (16'h1234 ^ 16'(k));
      add_row(1'b1, mk_retire(48'h4500, 48'h5000, gh, BR_COND, (k % 2) == 0, 1'b1),
              1'b0, 1);
      add_row(1'b1, mk_retire(48'h44f0, '0, gh, BR_UNCOND, 1'b0, 1'b1), 1'b0, 3);
    end
    // call chain ten deep, each call block followed by a return block
    for (int k = 0; k < 10; k++) begin
      blk = 48'h6000 + addr_t'(k) * 48'h20;
      add_row(1'b1, mk_retire(blk, blk + 48'h20, '0, BR_CALL, 1'b1, 1'b0), 1'b0, 0);
      add_row(1'b1, mk_retire(blk + 48'h10, '0, '0, BR_RET, 1'b1, 1'b0), 1'b0, 0);
    end
    add_row(1'b1, mk_retire(48'h6140, '0, '0, BR_RET, 1'b1, 1'b0), 1'b0, 0);
    add_row(1'b1, mk_retire(48'h5ff0, '0, '0, BR_UNCOND, 1'b0, 1'b1), 1'b0, 30);
    add_row(1'b0, '0, 1'b0, 20);
    // random back-pressure with random steering into the call region
    for (int k = 0; k < 40; k++) begin
      rng = xorshift(rng);
      blk = 48'h5ff0 + addr_t'({rng[8:4], 4'h0});
      add_row(rng[1:0] == 2'b00, mk_retire(blk, '0, rng[31:16], BR_UNCOND, 1'b0, 1'b1),
              1'b1, int'(rng[13:10]));
    end
  endtask

  initial begin
    clk          = 1'b0;
    rst          = 1'b1;
    fetch_ready  = 1'b0;
    retire_valid = 1'b0;
    retire       = '0;
    cycles       = 0;
    n_hs         = 0;
    n_rows       = 0;
    rng          = 32'h36f4;
    limit        = MAX_ROWS * 40 + 2048;
    for (int i = 0; i < 64; i++) begin
      m_v[i]    = 1'b0;
      m_tag[i]  = '0;
      m_tgt[i]  = '0;
      m_kind[i] = BR_COND;   // cleared entry
    end
    for (int i = 0; i < 1024; i++) begin
      m_a[i] = 1'b0;
      m_b[i] = 1'b0;
      m_c[i] = 1'b0;
    end
    for (int i = 0; i < RAS_DEPTH; i++) m_ras[i] = '0;
    m_cnt = '0;
    m_ptr = 0;
    m_pc  = RESET_PC;
    m_gh  = '0;
    build_table();
    limit = n_rows * 40 + 2048;

    repeat (5) @(posedge clk);
    rst <= 1'b0;
    // table clearing takes a while, fetch_valid marks the end
    do begin
      @(negedge clk);
    end while (fetch_valid !== 1'b1);
    check_addr(fetch.pc, RESET_PC, "first fetch address");

    for (int i = 0; i < n_rows; i++) begin
      run_cycle(rows[i].rv, rows[i].r, rows[i].bp);
      repeat (rows[i].idle) run_cycle(1'b0, '0, rows[i].bp);
    end
    @(negedge clk);   // model is one edge ahead
    check_addr(fetch.pc, m_pc, "final fetch address");

    $display("Simulation completed successfully");
    $finish;
  end

endmodule

// File: tests/fe_properties.sv
// fetch handshake assertions, bound into every fe_pc_gen instance
`timescale 1ns/1ps

module fe_properties (
  input logic            clk,
  input logic            rst,
  input logic            fetch_valid,
  input logic            fetch_ready,
  input fe_pkg::fetch_t  fetch,
  input logic            retire_valid
);

  // one cycle after rst the clear logic is known to be reset
  a_rst_quiet: assert property (@(posedge clk) rst |=> !fetch_valid)
    else $error("fetch_valid high during reset");

  a_aligned: assert property (@(posedge clk) disable iff (rst)
    fetch_valid |-> (fetch.pc[3:0] == 4'h0))
    else $error("fetch address not aligned to 16 bytes");

  // any retire may install or redirect, so only quiet cycles must hold
  a_stable: assert property (@(posedge clk) disable iff (rst)
    (fetch_valid && !fetch_ready && !retire_valid) |=> $stable(fetch))
    else $error("fetch changed while stalled");

endmodule

bind fe_pc_gen fe_properties u_props (
  .clk          (clk),
  .rst          (rst),
  .fetch_valid  (fetch_valid),
  .fetch_ready  (fetch_ready),
  .fetch        (fetch),
  .retire_valid (retire_valid)
);

// File: src/fe_top.sv
// fetch front end top, connects address generator, target buffer, predictor and return stack
`timescale 1ns/1ps

module fe_top #(
  parameter fe_pkg::addr_t RESET_PC  = 48'h0000_0000_1000,
  parameter int            RAS_DEPTH = 8
) (
  input  logic            clk,
  input  logic            rst,
  output fe_pkg::fetch_t  fetch,
  output logic            fetch_valid,
  input  logic            fetch_ready,
  input  logic            retire_valid,
  input  fe_pkg::retire_t retire
);

  import fe_pkg::*;

  addr_t      pc;
  ghist_t     ghist;
  logic       btb_hit;
  btb_entry_t btb_entry;
  logic       pred_taken;
  addr_t      ras_top;
  logic       ras_push;
  logic       ras_pop;
  logic       clear_done;

  fe_pc_gen #(
    .RESET_PC (RESET_PC)
  ) u_pc_gen (
    .clk          (clk),
    .rst          (rst),
    .ready_in     (clear_done),
    .pc           (pc),
    .ghist        (ghist),
    .btb_hit      (btb_hit),
    .btb_entry    (btb_entry),
    .pred_taken   (pred_taken),
    .ras_top      (ras_top),
    .ras_push     (ras_push),
    .ras_pop      (ras_pop),
    .fetch        (fetch),
    .fetch_valid  (fetch_valid),
    .fetch_ready  (fetch_ready),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  fe_btb u_btb (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .hit          (btb_hit),
    .entry        (btb_entry),
    .retire_valid (retire_valid),
    .retire       (retire)
  );

  fe_dir_pred u_dir_pred (
    .clk          (clk),
    .rst          (rst),
    .pc           (pc),
    .ghist        (ghist),
    .taken        (pred_taken),
    .retire_valid (retire_valid),
    .retire       (retire),
    .clear_done   (clear_done)   // largest tables, gates fetch
  );

  // return address is the block after the call
  fe_ras #(
    .DEPTH (RAS_DEPTH)
  ) u_ras (
    .clk       (clk),
    .rst       (rst),
    .push      (ras_push),
    .push_addr (pc + addr_t'(BLOCK_BYTES)),
    .pop       (ras_pop),
    .top       (ras_top)
  );

endmodule

// File: src/fe_pc_gen.sv
// fetch address and history registers with next-address choice and retire redirect
`timescale 1ns/1ps

module fe_pc_gen #(
  parameter fe_pkg::addr_t RESET_PC = '0
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               ready_in,
  output fe_pkg::addr_t      pc,
  output fe_pkg::ghist_t     ghist,
  input  logic               btb_hit,
  input  fe_pkg::btb_entry_t btb_entry,
  input  logic               pred_taken,
  input  fe_pkg::addr_t      ras_top,
  output logic               ras_push,
  output logic               ras_pop,
  output fe_pkg::fetch_t     fetch,
  output logic               fetch_valid,
  input  logic               fetch_ready,
  input  logic               retire_valid,
  input  fe_pkg::retire_t    retire
);

  import fe_pkg::*;

  logic   br_taken;
  logic   redirect;
  logic   hs;
  addr_t  next_pc;
  addr_t  redir_pc;
  ghist_t next_ghist;
  ghist_t redir_ghist;

  assign br_taken = btb_hit && ((btb_entry.kind != BR_COND) || pred_taken);

  always_comb begin
    if (!br_taken) next_pc = pc + addr_t'(BLOCK_BYTES);
    else if (btb_entry.kind == BR_RET) next_pc = ras_top;
    else next_pc = block_align(btb_entry.target);
  end

  assign next_ghist = btb_hit ? {ghist[HIST_W-2:0], br_taken} : ghist;

  assign redirect    = retire_valid && retire.mispredict;
  assign redir_pc    = retire.taken ? block_align(retire.target)
                                    : block_align(retire.src) + addr_t'(BLOCK_BYTES);
  assign redir_ghist = (retire.kind == BR_COND) ? {retire.ghist[HIST_W-2:0], retire.taken}
                                                : retire.ghist;

  // the block in flight on a redirect cycle is wrong path, hold it back
  assign fetch_valid = ready_in && !redirect;
  assign hs          = fetch_valid && fetch_ready;

  assign ras_push = hs && btb_hit && (btb_entry.kind == BR_CALL);
  assign ras_pop  = hs && btb_hit && (btb_entry.kind == BR_RET);

  always_ff @(posedge clk) begin
    if (rst) begin
      pc    <= RESET_PC;
      ghist <= '0;
    end else if (redirect) begin
      pc    <= redir_pc;
      ghist <= redir_ghist;
    end else if (hs) begin
      pc    <= next_pc;
      ghist <= next_ghist;
    end
  end

  always_comb begin
    fetch.pc    = pc;
    fetch.ghist = ghist;
    fetch.taken = br_taken;
    fetch.hit   = btb_hit;
    fetch.kind  = btb_entry.kind;
  end

endmodule

// File: src/fe_ras.sv
// circular return address stack, pushed on predicted calls and popped on predicted returns
`timescale 1ns/1ps

module fe_ras #(
  parameter int DEPTH = 8
) (
  input  logic          clk,
  input  logic          rst,
  input  logic          push,
  input  fe_pkg::addr_t push_addr,
  input  logic          pop,
  output fe_pkg::addr_t top
);

  import fe_pkg::*;

  localparam int PTR_W = $clog2(DEPTH);

  addr_t            stack [DEPTH];
  logic [PTR_W-1:0] ptr;
  logic [PTR_W-1:0] ptr_up;
  logic [PTR_W-1:0] ptr_dn;

  // explicit wrap so DEPTH need not be a power of two
  assign ptr_up = (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
  assign ptr_dn = (ptr == '0) ? PTR_W'(DEPTH - 1) : ptr - 1'b1;

  always_ff @(posedge clk) begin
    if (rst) begin
      ptr <= '0;
    end else if (push) begin
      ptr <= ptr_up;
    end else if (pop) begin
      ptr <= ptr_dn;
    end
  end

  always_ff @(posedge clk) begin
    if (push) stack[ptr_up] <= push_addr;   // oldest entry lost on overflow
  end

  assign top = stack[ptr];

endmodule

// File: src/fe_dir_pred.sv
// three-table xor direction predictor, trained by a counted flip rule on conditional mispredicts
`timescale 1ns/1ps

module fe_dir_pred (
  input  logic            clk,
  input  logic            rst,
  input  fe_pkg::addr_t   pc,
  input  fe_pkg::ghist_t  ghist,
  output logic            taken,
  input  logic            retire_valid,
  input  fe_pkg::retire_t retire,
  output logic            clear_done
);

  import fe_pkg::*;

  logic [PRED_IDX_W-1:0] fetch_idx [3];
  logic [PRED_IDX_W-1:0] ret_idx   [3];
  logic [2:0]            bit_rd;
  logic [2:0]            flip;
  logic [2:0]            tbl_done;
  logic [3:0]            miss_cnt;
  logic                  train;

  assign fetch_idx[0] = pred_idx(pc, ghist, IDX_A_SEL);
  assign fetch_idx[1] = pred_idx(pc, ghist, IDX_B_SEL);
  assign fetch_idx[2] = pred_idx(pc, ghist, IDX_C_SEL);

  assign ret_idx[0] = pred_idx(retire.src, retire.ghist, IDX_A_SEL);
  assign ret_idx[1] = pred_idx(retire.src, retire.ghist, IDX_B_SEL);
  assign ret_idx[2] = pred_idx(retire.src, retire.ghist, IDX_C_SEL);

  assign train = retire_valid && retire.mispredict && (retire.kind == BR_COND);

  // A every miss, B every 4th, C every 16th
  assign flip[0] = 1'b1;
  assign flip[1] = (miss_cnt[1:0] == 2'b11);
  assign flip[2] = (miss_cnt == 4'hf);

  always_ff @(posedge clk) begin
    if (rst) begin
      miss_cnt <= '0;
    end else if (train) begin
      miss_cnt <= miss_cnt + 1'b1;
    end
  end

  for (genvar i = 0; i < 3; i++) begin : g_tbl
    // read port goes to the retire index while training, no fetch transfers then
    fe_table #(
      .entry_t (logic),
      .IDX_W   (PRED_IDX_W)
    ) u_tbl (
      .clk        (clk),
      .rst        (rst),
      .raddr      (train ? ret_idx[i] : fetch_idx[i]),
      .rdata      (bit_rd[i]),
      .we         (train && flip[i]),
      .waddr      (ret_idx[i]),
      .wdata      (~bit_rd[i]),
      .clear_done (tbl_done[i])
    );
  end

  assign taken      = ^bit_rd;
  assign clear_done = &tbl_done;

endmodule

// File: src/fe_btb.sv
// branch target buffer, looked up by fetch block address and filled by taken retires
`timescale 1ns/1ps

module fe_btb (
  input  logic               clk,
  input  logic               rst,
  input  fe_pkg::addr_t      pc,
  output logic               hit,
  output fe_pkg::btb_entry_t entry,
  input  logic               retire_valid,
  input  fe_pkg::retire_t    retire
);

  import fe_pkg::*;

  logic [BTB_IDX_W-1:0] rd_idx;
  logic [BTB_IDX_W-1:0] wr_idx;
  btb_entry_t           rd_entry;
  btb_entry_t           wr_entry;
  logic                 install;

  assign rd_idx = pc[BLOCK_LSB +: BTB_IDX_W];
  assign wr_idx = retire.src[BLOCK_LSB +: BTB_IDX_W];

  // only taken branches earn an entry
  assign install = retire_valid && retire.taken;

  always_comb begin
    wr_entry.valid  = 1'b1;
    wr_entry.tag    = retire.src[ADDR_W-1:BTB_TAG_LSB];
    wr_entry.target = retire.target;
    wr_entry.kind   = retire.kind;
  end

  fe_table #(
    .entry_t (btb_entry_t),
    .IDX_W   (BTB_IDX_W)
  ) u_tbl (
    .clk        (clk),
    .rst        (rst),
    .raddr      (rd_idx),
    .rdata      (rd_entry),
    .we         (install),
    .waddr      (wr_idx),
    .wdata      (wr_entry),
    .clear_done ()         // shorter than the predictor tables
  );

  assign hit   = rd_entry.valid && (rd_entry.tag == pc[ADDR_W-1:BTB_TAG_LSB]);
  assign entry = rd_entry;

endmodule

// File: src/fe_table.sv
// generic table with async read and sync write, self-clearing after reset; payload by type
`timescale 1ns/1ps

module fe_table #(
  parameter type entry_t = logic,
  parameter int  IDX_W   = 6
) (
  input  logic             clk,
  input  logic             rst,
  input  logic [IDX_W-1:0] raddr,
  output entry_t           rdata,
  input  logic             we,
  input  logic [IDX_W-1:0] waddr,
  input  entry_t           wdata,
  output logic             clear_done
);

  entry_t           mem [2**IDX_W];
  logic [IDX_W-1:0] clr_idx;

  always_ff @(posedge clk) begin
    if (rst) begin
      clr_idx    <= '0;
      clear_done <= 1'b0;
    end else if (!clear_done) begin
      clr_idx    <= clr_idx + 1'b1;
      clear_done <= &clr_idx;   // last entry this cycle
    end
  end

  // clearing owns the write port until done
  always_ff @(posedge clk) begin
    if (!clear_done) begin
      mem[clr_idx] <= '0;
    end else if (we) begin
      mem[waddr] <= wdata;
    end
  end

  assign rdata = mem[raddr];

endmodule

// File: src/fe_pkg.sv
// shared widths, index helpers and record types, imported by every front-end module
package fe_pkg;

  localparam int ADDR_W      = 48;
  localparam int BLOCK_BYTES = 16;
  localparam int BLOCK_LSB   = 4;   // first bit above the block offset
  localparam int HIST_W      = 16;
  localparam int BTB_IDX_W   = 6;   // pc[9:4]
  localparam int PRED_IDX_W  = 10;

  localparam int BTB_TAG_LSB = BLOCK_LSB + BTB_IDX_W;
  localparam int BTB_TAG_W   = ADDR_W - BTB_TAG_LSB;

  // history bits per predictor index, the rest of the index is pc[..:4]
  localparam int unsigned IDX_A_SEL = 2;   // pc[11:4], ghist[1:0]
  localparam int unsigned IDX_B_SEL = 6;   // pc[7:4], ghist[5:0]
  localparam int unsigned IDX_C_SEL = 10;  // history only

  typedef logic [ADDR_W-1:0] addr_t;
  typedef logic [HIST_W-1:0] ghist_t;

  typedef enum logic [1:0] {
    BR_COND   = 2'd0,
    BR_UNCOND = 2'd1,
    BR_CALL   = 2'd2,
    BR_RET    = 2'd3
  } br_kind_t;

  typedef struct packed {
    logic                 valid;
    logic [BTB_TAG_W-1:0] tag;
    addr_t                target;
    br_kind_t             kind;
  } btb_entry_t;

  typedef struct packed {
    addr_t    pc;
    ghist_t   ghist;   // history the block was predicted with
    logic     taken;
    logic     hit;
    br_kind_t kind;    // only valid with hit
  } fetch_t;

  typedef struct packed {
    addr_t    src;     // block address of the branch
    addr_t    target;
    ghist_t   ghist;
    br_kind_t kind;
    logic     taken;
    logic     mispredict;
  } retire_t;

  // index = {pc bits, low history bits}, pc part drops out when hist_bits covers all
  function automatic logic [PRED_IDX_W-1:0] pred_idx(addr_t a, ghist_t gh,
                                                     int unsigned hist_bits);
    logic [PRED_IDX_W-1:0] a_part;
    logic [PRED_IDX_W-1:0] h_part;
    a_part = PRED_IDX_W'(a >> BLOCK_LSB) << hist_bits;
    h_part = PRED_IDX_W'(gh) & ({PRED_IDX_W{1'b1}} >> (PRED_IDX_W - hist_bits));
    return a_part | h_part;
  endfunction

  function automatic addr_t block_align(addr_t a);
    return {a[ADDR_W-1:BLOCK_LSB], {BLOCK_LSB{1'b0}}};
  endfunction

endpackage
